// File: src/dpram_pkg.sv
// ######################################
// dpram_pkg
// shared widths, word types and the write
// request carried from the write port to
// the memory and the read port
// ######################################

`default_nettype none

package dpram_pkg;

    // logical memory geometry
    localparam int DATA_W = 64;          // word width
    localparam int ADDR_W = 9;           // 512 words
    localparam int BE_W   = DATA_W / 8;  // one enable per byte lane

    // one memory word
    typedef logic [DATA_W-1:0] data_t;

    // one word address
    typedef logic [ADDR_W-1:0] addr_t;

    // byte enables, one bit per lane
    typedef logic [BE_W-1:0] be_t;

    // registered write request
    typedef struct packed {
        addr_t addr;  // word address
        data_t data;  // write data
        data_t mask;  // bit mask, one bit per data bit
    } wr_req_t;

endpackage

`default_nettype wire

// File: src/wr_port.sv
// ######################################
// wr_port
// registers a write request and expands
// the byte enables into a bit mask
// ######################################

`timescale 1ns/100ps
`default_nettype none

module wr_port (
    input  wire              clk,
    input  wire              reset,
    input  wire              wr_en,      // write strobe
    input  dpram_pkg::addr_t wr_addr,
    input  dpram_pkg::be_t   wr_be,      // byte enables
    input  dpram_pkg::data_t wr_data,
    output logic             wr_req_en,  // qualifies wr_req
    output dpram_pkg::wr_req_t wr_req
);

    dpram_pkg::data_t mask_d;  // expanded byte enables
    logic             wr_go;   // write with at least one lane

    // each enable covers the eight bits of its lane
    always_comb begin
        mask_d = '0;
        for (int i = 0; i < dpram_pkg::BE_W; i++) begin
            mask_d[8*i +: 8] = {8{wr_be[i]}};
        end
    end

    assign wr_go = wr_en & (|wr_be);  // empty writes stop here

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_req_en <= 1'b0;
        end else begin
            wr_req_en <= wr_go;
        end
    end

    // payload only moves with a real write
    always_ff @(posedge clk) begin
        if (wr_go) begin
            wr_req.addr <= wr_addr;
            wr_req.data <= wr_data;
            wr_req.mask <= mask_d;
        end
    end

endmodule

`default_nettype wire

// File: src/dp_macro.sv
// ######################################
// dp_macro
// behavioral model of one dual port macro
// masked write port, synchronous read
// port with old data on a collision
// ######################################

`timescale 1ns/100ps
`default_nettype none

module dp_macro #(
    parameter int MACRO_AW = 8,   // macro address width
    parameter int MACRO_DW = 32   // macro data width
) (
    input  wire                 clk,
    // write port
    input  wire                 wr_ce,    // write chip enable
    input  wire  [MACRO_AW-1:0] wr_addr,
    input  wire  [MACRO_DW-1:0] wr_mask,  // per bit write enable
    input  wire  [MACRO_DW-1:0] wr_din,
    // read port
    input  wire                 rd_ce,    // read chip enable
    input  wire  [MACRO_AW-1:0] rd_addr,
    output logic [MACRO_DW-1:0] rd_dout
);

    localparam int DEPTH = 2 ** MACRO_AW;

    logic [MACRO_DW-1:0] mem [DEPTH];  // storage array

    // only bits with a set mask bit change
    always_ff @(posedge clk) begin
        if (wr_ce) begin
            mem[wr_addr] <= (mem[wr_addr] & ~wr_mask) | (wr_din & wr_mask);
        end
    end

    // output holds while rd_ce is low
    always_ff @(posedge clk) begin
        if (rd_ce) begin
            rd_dout <= mem[rd_addr];  // sees the word before a same-edge write
        end
    end

endmodule

`default_nettype wire

// File: src/la_dpram.sv
// ######################################
// la_dpram
// logical dual port memory tiled from
// fixed size macros in width and depth
// upper address bits pick the bank and
// the bank outputs are OR-reduced
// ######################################

`timescale 1ns/100ps
`default_nettype none

module la_dpram #(
    parameter int MACRO_AW = 8,   // macro address width
    parameter int MACRO_DW = 32   // macro data width
) (
    input  wire                clk,
    // write side
    input  wire                wr_req_en,  // write strobe
    input  dpram_pkg::wr_req_t wr_req,
    // read side
    input  wire                rd_en,      // read strobe
    input  dpram_pkg::addr_t   rd_addr,
    output dpram_pkg::data_t   rd_dout
);

    localparam int ADDR_W = dpram_pkg::ADDR_W;
    localparam int DATA_W = dpram_pkg::DATA_W;

    // number of banks in depth, a single bank when one macro holds all words
    localparam int BANKS   = (ADDR_W > MACRO_AW) ? 2 ** (ADDR_W - MACRO_AW) : 1;
    localparam int BANK_AW = (ADDR_W > MACRO_AW) ? ADDR_W - MACRO_AW : 1;

    // number of slices in width, last slice padded with zero
    localparam int SLICES = (DATA_W + MACRO_DW - 1) / MACRO_DW;
    localparam int PAD_W  = SLICES * MACRO_DW;

    logic [PAD_W-1:0]    wr_din_pad;   // zero padded write data
    logic [PAD_W-1:0]    wr_mask_pad;  // zero padded write mask
    logic [MACRO_AW-1:0] wr_mem_addr;  // address inside a macro
    logic [MACRO_AW-1:0] rd_mem_addr;

    wire  [BANKS-1:0]            wr_sel;     // write bank select
    wire  [BANKS-1:0]            rd_sel;     // read bank select
    logic [BANKS-1:0]            rd_sel_q;   // select of the last read
    wire  [BANKS-1:0][PAD_W-1:0] bank_dout;  // gated bank outputs
    logic [DATA_W-1:0]           rd_or;

    always_comb begin
        wr_din_pad  = '0;
        wr_mask_pad = '0;  // padding bits are never written
        wr_din_pad[DATA_W-1:0]  = wr_req.data;
        wr_mask_pad[DATA_W-1:0] = wr_req.mask;
    end

    // lower address bits go to every macro
    assign wr_mem_addr = MACRO_AW'(wr_req.addr);
    assign rd_mem_addr = MACRO_AW'(rd_addr);

    // remember which bank answers the read in flight
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_sel_q <= rd_sel;
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        wire [PAD_W-1:0] dout_raw;  // concatenated slice outputs

        if (BANKS == 1) begin : g_fits
            assign wr_sel[b] = 1'b1;
            assign rd_sel[b] = 1'b1;
        end else begin : g_split
            assign wr_sel[b] = (wr_req.addr[ADDR_W-1:MACRO_AW] == BANK_AW'(b));
            assign rd_sel[b] = (rd_addr[ADDR_W-1:MACRO_AW] == BANK_AW'(b));
        end

        for (genvar s = 0; s < SLICES; s++) begin : g_slice
            dp_macro #(
                .MACRO_AW (MACRO_AW),
                .MACRO_DW (MACRO_DW)
            ) i_macro (
                .clk     (clk),
                .wr_ce   (wr_req_en & wr_sel[b]),
                .wr_addr (wr_mem_addr),
                .wr_mask (wr_mask_pad[s*MACRO_DW +: MACRO_DW]),
                .wr_din  (wr_din_pad[s*MACRO_DW +: MACRO_DW]),
                .rd_ce   (rd_en & rd_sel[b]),
                .rd_addr (rd_mem_addr),
                .rd_dout (dout_raw[s*MACRO_DW +: MACRO_DW])
            );
        end

        // banks not read last cycle contribute zero
        assign bank_dout[b] = rd_sel_q[b] ? dout_raw : '0;
    end

    // each output bit is the OR over the banks
    always_comb begin
        rd_or = '0;
        for (int b = 0; b < BANKS; b++) begin
            rd_or = rd_or | bank_dout[b][DATA_W-1:0];
        end
    end

    assign rd_dout = rd_or;

endmodule

`default_nettype wire

// File: src/rd_port.sv
// ######################################
// rd_port
// registers reads toward the memory,
// raises rd_valid two cycles later and
// forwards write data on a collision
// ######################################

`timescale 1ns/100ps
`default_nettype none

module rd_port (
    input  wire                clk,
    input  wire                reset,
    // request side
    input  wire                rd_en,        // read strobe
    input  dpram_pkg::addr_t   rd_addr,
    // write snoop
    input  wire                wr_req_en,
    input  dpram_pkg::wr_req_t wr_req,
    // memory side
    output logic               mem_rd_en,
    output dpram_pkg::addr_t   mem_rd_addr,
    input  dpram_pkg::data_t   mem_rd_data,
    // response side
    output logic               rd_valid,
    output dpram_pkg::data_t   rd_data
);

    logic             hit;       // read and write meet on this edge
    dpram_pkg::data_t fwd_data;  // captured write data
    dpram_pkg::data_t fwd_mask;  // bits to take from fwd_data

    // strobe pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rd_en <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            mem_rd_en <= rd_en;
            rd_valid  <= mem_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_rd_addr <= rd_addr;
        end
    end

    // memory returns old data when the write lands on the same edge
    assign hit = mem_rd_en & wr_req_en & (mem_rd_addr == wr_req.addr);

    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            fwd_data <= wr_req.data;
            fwd_mask <= hit ? wr_req.mask : '0;  // no hit, pass memory data
        end
    end

    // write first merge over the memory word
    assign rd_data = (mem_rd_data & ~fwd_mask) | (fwd_data & fwd_mask);

endmodule

`default_nettype wire

// File: src/dpram_sub.sv
// ######################################
// dpram_sub
// dual port memory subsystem
// write port, tiled memory and read port
// ######################################

`timescale 1ns/100ps
`default_nettype none

module dpram_sub #(
    parameter int MACRO_AW = 8,   // macro address width
    parameter int MACRO_DW = 32   // macro data width
) (
    input  wire              clk,
    input  wire              reset,
    // write side
    input  wire              wr_en,
    input  dpram_pkg::addr_t wr_addr,
    input  dpram_pkg::be_t   wr_be,
    input  dpram_pkg::data_t wr_data,
    // read side
    input  wire              rd_en,
    input  dpram_pkg::addr_t rd_addr,
    output logic             rd_valid,
    output dpram_pkg::data_t rd_data
);

    logic               wr_req_en;
    dpram_pkg::wr_req_t wr_req;
    logic               mem_rd_en;
    dpram_pkg::addr_t   mem_rd_addr;
    dpram_pkg::data_t   mem_rd_data;

    wr_port i_wr_port (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_be     (wr_be),
        .wr_data   (wr_data),
        .wr_req_en (wr_req_en),
        .wr_req    (wr_req)
    );

    la_dpram #(
        .MACRO_AW (MACRO_AW),
        .MACRO_DW (MACRO_DW)
    ) i_la_dpram (
        .clk       (clk),
        .wr_req_en (wr_req_en),
        .wr_req    (wr_req),
        .rd_en     (mem_rd_en),
        .rd_addr   (mem_rd_addr),
        .rd_dout   (mem_rd_data)
    );

    rd_port i_rd_port (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .wr_req_en   (wr_req_en),
        .wr_req      (wr_req),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: testbench/dpram_sub_sva.sv
// ######################################
// dpram_sub_sva
// timing checks on the top level ports
// of the memory subsystem, bound into
// every dpram_sub instance
// ######################################

`timescale 1ns/100ps
`default_nettype none

module dpram_sub_sva (
    input wire              clk,
    input wire              reset,
    input wire              rd_en,
    input wire              rd_valid,
    input dpram_pkg::data_t rd_data
);

    int sva_errors = 0;  // failed timing checks

    // fixed read latency of two edges, nothing extra and nothing lost
    a_rd_latency : assert property (@(posedge clk) disable iff (reset)
        rd_valid == $past(rd_en, 2))
        else begin
            sva_errors++;
            $error("rd_valid does not follow rd_en by exactly two cycles");
        end

    a_valid_after_reset : assert property (@(posedge clk)
        $fell(reset) |-> !rd_valid)  // pipeline empty on release
        else begin
            sva_errors++;
            $error("rd_valid high in the first cycle after reset");
        end

    a_data_known : assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> !$isunknown(rd_data))
        else begin
            sva_errors++;
            $error("rd_data has X or Z bits while rd_valid is high");
        end

endmodule

bind dpram_sub dpram_sub_sva i_sva (
    .clk      (clk),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
);

`default_nettype wire

// File: testbench/dpram_sub_tb.sv
// ########################################
// dpram_sub_tb
// testbench for the dual port memory
// subsystem, drives both ports and checks
// reads against a shadow copy of memory
// ########################################

`timescale 1ns/100ps
`default_nettype none

module dpram_sub_tb;

    localparam int DEPTH      = 2 ** dpram_pkg::ADDR_W;
    localparam int BANK_WORDS = 256;  // words per bank with the default macro

    logic             clk;
    logic             reset;
    logic             wr_en;
    dpram_pkg::addr_t wr_addr;
    dpram_pkg::be_t   wr_be;
    dpram_pkg::data_t wr_data;
    logic             rd_en;
    dpram_pkg::addr_t rd_addr;
    logic             rd_valid;
    dpram_pkg::data_t rd_data;

    dpram_pkg::data_t model [DEPTH];  // shadow memory
    dpram_pkg::data_t exp_s1;         // expected word after the read edge
    dpram_pkg::data_t exp_s2;         // lines up with rd_valid
    int errors      = 0;
    int read_count  = 0;  // reads sampled by the DUT
    int valid_count = 0;  // rd_valid cycles seen

    dpram_sub i_dut (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_be    (wr_be),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // only lanes with their enable set take the new byte
    function automatic dpram_pkg::data_t merge_bytes(input dpram_pkg::data_t old_word,
                                                     input dpram_pkg::data_t new_word,
                                                     input dpram_pkg::be_t   be);
        dpram_pkg::data_t result;
        result = old_word;
        for (int i = 0; i < dpram_pkg::BE_W; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic dpram_pkg::data_t random_word();
        return {$urandom, $urandom};
    endfunction

    // a few words in each bank, so hits and repeats are common
    function automatic dpram_pkg::addr_t hot_addr();
        logic [31:0] r;
        r = $urandom;
        return dpram_pkg::addr_t'(r[3] ? BANK_WORDS + 32'(r[2:0]) : 32'(r[2:0]));
    endfunction

    // shadow update first, so a same-edge read sees the new word
    always @(posedge clk) begin
        if (!reset) begin
            if (wr_en) begin
                model[wr_addr] = merge_bytes(model[wr_addr], wr_data, wr_be);
            end
            if (rd_en) begin
                read_count++;
            end
            if (rd_valid) begin
                valid_count++;
            end
        end
        exp_s1 <= model[rd_addr];
        exp_s2 <= exp_s1;
    end

    a_rd_data : assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> rd_data == exp_s2)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: rd_data %h, expected %h",
                     $time, $sampled(rd_data), $sampled(exp_s2));
        end

    // one cycle of both ports, strobes drop again afterwards
    task automatic drive_cycle(input logic we, input dpram_pkg::addr_t wa,
                               input dpram_pkg::data_t wd, input dpram_pkg::be_t be,
                               input logic re, input dpram_pkg::addr_t ra);
        wr_en   = we;
        wr_addr = wa;
        wr_data = wd;
        wr_be   = be;
        rd_en   = re;
        rd_addr = ra;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic drain_reads();
        int wait_cycles;
        wait_cycles = 0;
        while (valid_count != read_count && wait_cycles < 10) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (valid_count != read_count) begin
            $display("timeout at %0t: %0d reads issued but %0d rd_valid cycles seen",
                     $time, read_count, valid_count);
            errors++;
        end
    endtask

    task automatic full_word_pass();
        for (int a = 0; a < DEPTH; a++) begin
            drive_cycle(1'b1, dpram_pkg::addr_t'(a), random_word(), '1, 1'b0, '0);
        end
        for (int a = 0; a < DEPTH; a++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, dpram_pkg::addr_t'(a));
        end
        drain_reads();
    endtask

    // random or empty byte enables, each write read back at once
    task automatic byte_enable_pass(input int count, input logic empty);
        dpram_pkg::addr_t addr;
        dpram_pkg::be_t   be;
        for (int i = 0; i < count; i++) begin
            addr = dpram_pkg::addr_t'($urandom);
            be   = empty ? '0 : dpram_pkg::be_t'($urandom);
            drive_cycle(1'b1, addr, random_word(), be, 1'b0, '0);
            drive_cycle(1'b0, '0, '0, '0, 1'b1, addr);
        end
        drain_reads();
    endtask

    task automatic collision_pass();
        dpram_pkg::addr_t addr;
        for (int i = 0; i < 16; i++) begin
            addr = dpram_pkg::addr_t'($urandom);
            drive_cycle(1'b1, addr, random_word(), dpram_pkg::be_t'($urandom), 1'b1, addr);
            drive_cycle(1'b1, addr, random_word(), '1, 1'b1, addr ^ 9'h100);  // other bank
            drive_cycle(1'b1, addr, random_word(), '1, 1'b1, addr ^ 9'h001);  // same bank
        end
        drain_reads();
    endtask

    task automatic interleaved_reads();
        for (int i = 0; i < 32; i++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1,
                        dpram_pkg::addr_t'(i[0] ? BANK_WORDS + i : i));
        end
        drain_reads();
    endtask

    task automatic random_mix();
        for (int i = 0; i < 400; i++) begin
            drive_cycle(1'($urandom), hot_addr(), random_word(),
                        dpram_pkg::be_t'($urandom), 1'($urandom), hot_addr());
        end
        drain_reads();
    endtask

    initial begin
        void'($urandom(32'h3e6));
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_be   = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        full_word_pass();
        byte_enable_pass(32, 1'b0);
        byte_enable_pass(8, 1'b1);
        collision_pass();
        interleaved_reads();
        random_mix();

        $display("errors: %0d data or timeout, %0d timing", errors, i_dut.i_sva.sva_errors);
        if (errors == 0 && i_dut.i_sva.sva_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dpram_sub.f
src/dpram_pkg.sv
src/wr_port.sv
src/dp_macro.sv
src/la_dpram.sv
src/rd_port.sv
src/dpram_sub.sv
testbench/dpram_sub_sva.sv
testbench/dpram_sub_tb.sv

// File: Makefile
SIM  := obj_dir/Vdpram_sub_tb
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): dpram_sub.f $(SRCS)
	verilator --binary --timing --assert --top-module dpram_sub_tb -f dpram_sub.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
